/* hdl/axi_rd_cfg.svh */
`ifndef AXI_RD_CFG_SVH
`define AXI_RD_CFG_SVH

// ----------------------------------------------------------
// bus widths
// ----------------------------------------------------------

`define AXI_ADDR_W  32      // byte address
`define S_DATA_W    32      // narrow side word
`define M_DATA_W    128     // wide memory beat
`define LEN_W       8       // axi len field, beats minus one

// ----------------------------------------------------------
// buffer depths, log2
// ----------------------------------------------------------

`define RBUF_AW     4       // wide read data fifo
`define LQ_AW       2       // narrow length queue

`endif

/* hdl/axi_rd_pkg.sv */
`include "axi_rd_cfg.svh"

package axi_rd_pkg;

    // ----------------------------------------------------------
    // derived sizes
    // ----------------------------------------------------------

    localparam int word_ratio      = `M_DATA_W / `S_DATA_W;
    localparam int ratio_bits      = $clog2(word_ratio);
    localparam int beat_align_bits = $clog2(`M_DATA_W / 8);   // bytes per wide beat

    // ----------------------------------------------------------
    // payload types
    // ----------------------------------------------------------

    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`LEN_W-1:0]      len_t;
    typedef logic [`S_DATA_W-1:0]   s_word_t;
    typedef logic [`M_DATA_W-1:0]   m_beat_t;

    // unpacker control
    typedef enum logic [1:0] {
        UNPACK_IDLE,
        UNPACK_RUN,
        UNPACK_DROP     // swallow the rest of the wide burst
    } unpack_state_t;

endpackage

/* hdl/rd_beat_if.sv */
// wide beat stream between the data fifo and the unpacker
interface rd_beat_if
    import axi_rd_pkg::*;
    ();

    m_beat_t data;
    logic    last;      // final beat of the memory burst
    logic    valid;
    logic    ready;

    modport src (
        output data,
        output last,
        output valid,
        input  ready
    );

    modport snk (
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface

/* hdl/ar_len_convert.sv */
module ar_len_convert
    import axi_rd_pkg::*;
    (
        input  logic  aclk,
        input  logic  rst_n,

        // narrow command
        input  addr_t s_araddr,
        input  len_t  s_arlen,
        input  logic  s_arvalid,
        output logic  s_arready,

        // wide command to memory
        output addr_t m_araddr,
        output len_t  m_arlen,
        output logic  m_arvalid,
        input  logic  m_arready,

        // narrow length to the unpacker
        output len_t  lq_len,
        output logic  lq_valid,
        input  logic  lq_ready
    );

    localparam addr_t align_mask = addr_t'((1 << beat_align_bits) - 1);

    logic run_q;        // low during reset and the cycle after
    logic reg_free;
    logic accept;
    addr_t aligned_addr;
    len_t  wide_len;

    // ----------------------------------------------------------
    // address and length conversion
    // ----------------------------------------------------------

    // low address bits below the wide beat are ignored
    assign aligned_addr = s_araddr & ~align_mask;

    // ceil((len+1)/ratio)-1 reduces to a plain shift
    assign wide_len = s_arlen >> ratio_bits;

    // ----------------------------------------------------------
    // handshake
    // ----------------------------------------------------------

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign reg_free = !m_arvalid || m_arready;   // empty or draining

    // the length push must not depend on lq_ready
    assign lq_valid  = run_q && reg_free && s_arvalid;
    assign lq_len    = s_arlen;
    assign s_arready = run_q && reg_free && lq_ready;
    assign accept    = s_arvalid && s_arready;

    // ----------------------------------------------------------
    // output register
    // ----------------------------------------------------------

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            m_arvalid <= 1'b0;
        end else if (accept) begin
            m_arvalid <= 1'b1;
        end else if (m_arready) begin
            m_arvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            m_araddr <= aligned_addr;
            m_arlen  <= wide_len;
        end
    end

endmodule

/* hdl/rdata_buffer.sv */
`include "axi_rd_cfg.svh"

module rdata_buffer
    import axi_rd_pkg::*;
    (
        input  logic    aclk,
        input  logic    rst_n,

        // wide read data from memory
        input  m_beat_t m_rdata,
        input  logic    m_rlast,
        input  logic    m_rvalid,
        output logic    m_rready,

        rd_beat_if.src  beat,

        // burst completion
        output logic    s_cvalid,
        input  logic    s_cready
    );

    localparam int depth = 2 ** `RBUF_AW;
    localparam int cnt_w = 8;       // outstanding completions

    logic [`M_DATA_W:0] mem [depth];   // {last, data}
    logic [`RBUF_AW:0]  wr_ptr;
    logic [`RBUF_AW:0]  rd_ptr;
    logic               empty;
    logic               full;
    logic               run_q;
    logic               wr;
    logic               out_take;
    logic               out_valid;
    logic               out_last;
    m_beat_t            out_data;
    logic [cnt_w-1:0]   pending;

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`RBUF_AW] != rd_ptr[`RBUF_AW])
                && (wr_ptr[`RBUF_AW-1:0] == rd_ptr[`RBUF_AW-1:0]);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign m_rready = run_q && !full;
    assign wr       = m_rvalid && m_rready;
    assign out_take = !out_valid || beat.ready;

    // bypass straight into the output stage when nothing is queued
    always_ff @(posedge aclk) begin
        if (wr && !(out_take && empty)) begin
            mem[wr_ptr[`RBUF_AW-1:0]] <= {m_rlast, m_rdata};
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr && !(out_take && empty)) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_take) begin
                if (!empty) begin
                    rd_ptr    <= rd_ptr + 1'b1;
                    out_valid <= 1'b1;
                end else begin
                    out_valid <= wr;
                end
            end
        end
    end

    // output stage payload
    always_ff @(posedge aclk) begin
        if (out_take) begin
            if (!empty) begin
                {out_last, out_data} <= mem[rd_ptr[`RBUF_AW-1:0]];
            end else if (wr) begin
                {out_last, out_data} <= {m_rlast, m_rdata};
            end
        end
    end

    assign beat.data  = out_data;
    assign beat.last  = out_last;
    assign beat.valid = out_valid;

    // ----------------------------------------------------------
    // completion counter
    // ----------------------------------------------------------

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            case ({wr && m_rlast, s_cvalid && s_cready})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

    assign s_cvalid = (pending != '0);

endmodule

/* hdl/beat_unpack.sv */
`include "axi_rd_cfg.svh"

module beat_unpack
    import axi_rd_pkg::*;
    (
        input  logic    aclk,
        input  logic    rst_n,
        input  logic    endian,     // 1 reverses word order in a beat

        // narrow length queue
        input  len_t    lq_len,
        input  logic    lq_valid,
        output logic    lq_ready,

        rd_beat_if.snk  beat,

        // narrow read data
        output s_word_t s_rdata,
        output logic    s_rlast,
        output logic    s_rvalid,
        input  logic    s_rready
    );

    localparam int lq_depth = 2 ** `LQ_AW;

    len_t               lq_mem [lq_depth];
    logic [`LQ_AW:0]    lq_wp;
    logic [`LQ_AW:0]    lq_rp;
    logic               lq_empty;
    logic               lq_full;
    logic               lq_pop;
    len_t               cur_len;

    unpack_state_t      state;
    len_t               word_cnt;   // narrow words sent in this burst
    logic [ratio_bits-1:0] sub;
    logic [ratio_bits-1:0] sel;
    logic               last_word;
    logic               xfer;

    // ----------------------------------------------------------
    // length queue
    // ----------------------------------------------------------

    assign lq_empty = (lq_wp == lq_rp);
    assign lq_full  = (lq_wp[`LQ_AW] != lq_rp[`LQ_AW])
                   && (lq_wp[`LQ_AW-1:0] == lq_rp[`LQ_AW-1:0]);
    assign lq_ready = !lq_full;
    assign cur_len  = lq_mem[lq_rp[`LQ_AW-1:0]];

    always_ff @(posedge aclk) begin
        if (lq_valid && lq_ready) begin
            lq_mem[lq_wp[`LQ_AW-1:0]] <= lq_len;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            lq_wp <= '0;
            lq_rp <= '0;
        end else begin
            if (lq_valid && lq_ready) begin
                lq_wp <= lq_wp + 1'b1;
            end
            if (lq_pop) begin
                lq_rp <= lq_rp + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // word select
    // ----------------------------------------------------------

    assign sub       = word_cnt[ratio_bits-1:0];   // bursts start beat aligned
    assign sel       = endian ? ratio_bits'(word_ratio - 1) - sub : sub;
    assign last_word = (word_cnt == cur_len);

    assign s_rvalid = (state == UNPACK_RUN) && beat.valid;
    assign s_rdata  = beat.data[sel*`S_DATA_W +: `S_DATA_W];
    assign s_rlast  = (state == UNPACK_RUN) && last_word;
    assign xfer     = s_rvalid && s_rready;

    always_comb begin
        case (state)
            UNPACK_RUN:  beat.ready = xfer && (last_word || (&sub));
            UNPACK_DROP: beat.ready = 1'b1;
            default:     beat.ready = 1'b0;
        endcase
    end

    assign lq_pop = (state == UNPACK_RUN  && xfer && last_word && beat.last)
                 || (state == UNPACK_DROP && beat.valid && beat.last);

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= UNPACK_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                UNPACK_IDLE: begin
                    word_cnt <= '0;
                    if (!lq_empty) begin
                        state <= UNPACK_RUN;
                    end
                end
                UNPACK_RUN: begin
                    if (xfer) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= beat.last ? UNPACK_IDLE : UNPACK_DROP;
                        end
                    end
                end
                UNPACK_DROP: begin
                    if (beat.valid && beat.last) begin
                        state <= UNPACK_IDLE;
                    end
                end
                default: state <= UNPACK_IDLE;
            endcase
        end
    end

endmodule

/* hdl/axi_rd_width_convert.sv */
module axi_rd_width_convert
    import axi_rd_pkg::*;
    (
        input  logic    aclk,
        input  logic    rst_n,
        input  logic    endian,

        // narrow read address
        input  addr_t   s_araddr,
        input  len_t    s_arlen,
        input  logic    s_arvalid,
        output logic    s_arready,

        // narrow read data
        output s_word_t s_rdata,
        output logic    s_rlast,
        output logic    s_rvalid,
        input  logic    s_rready,

        // completion acknowledge
        output logic    s_cvalid,
        input  logic    s_cready,

        // wide read address
        output addr_t   m_araddr,
        output len_t    m_arlen,
        output logic    m_arvalid,
        input  logic    m_arready,

        // wide read data
        input  m_beat_t m_rdata,
        input  logic    m_rlast,
        input  logic    m_rvalid,
        output logic    m_rready
    );

    len_t lq_len;
    logic lq_valid;
    logic lq_ready;

    rd_beat_if beat_bus ();

    // ----------------------------------------------------------
    // command path
    // ----------------------------------------------------------

    ar_len_convert u_ar_len_convert (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .s_araddr  (s_araddr),
        .s_arlen   (s_arlen),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .lq_len    (lq_len),
        .lq_valid  (lq_valid),
        .lq_ready  (lq_ready)
    );

    // ----------------------------------------------------------
    // data path
    // ----------------------------------------------------------

    rdata_buffer u_rdata_buffer (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .m_rdata  (m_rdata),
        .m_rlast  (m_rlast),
        .m_rvalid (m_rvalid),
        .m_rready (m_rready),
        .beat     (beat_bus.src),
        .s_cvalid (s_cvalid),
        .s_cready (s_cready)
    );

    beat_unpack u_beat_unpack (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .endian   (endian),
        .lq_len   (lq_len),
        .lq_valid (lq_valid),
        .lq_ready (lq_ready),
        .beat     (beat_bus.snk),
        .s_rdata  (s_rdata),
        .s_rlast  (s_rlast),
        .s_rvalid (s_rvalid),
        .s_rready (s_rready)
    );

endmodule

/* tb/axi_rd_assertions.sv */
module axi_rd_assertions
    import axi_rd_pkg::*;
    (
        input logic    aclk,
        input logic    rst_n,
        input addr_t   s_araddr,
        input len_t    s_arlen,
        input logic    s_arvalid,
        input logic    s_arready,
        input addr_t   m_araddr,
        input len_t    m_arlen,
        input logic    m_arvalid,
        input logic    m_arready,
        input s_word_t s_rdata,
        input logic    s_rlast,
        input logic    s_rvalid,
        input logic    s_rready,
        input logic    s_cvalid,
        input logic    s_cready,
        input logic    m_rready
    );

    int fail_reset   = 0;
    int fail_exit    = 0;
    int fail_ar_hold = 0;
    int fail_r_hold  = 0;
    int fail_c_hold  = 0;
    int fail_ar_lat  = 0;
    int fail_count;

    assign fail_count = fail_reset + fail_exit + fail_ar_hold
                      + fail_r_hold + fail_c_hold + fail_ar_lat;

    // ------------------------------------------------------------
    // reset behavior
    // ------------------------------------------------------------

    a_reset_quiet: assert property (@(posedge aclk)
        !rst_n |-> !(s_arready || m_arvalid || s_rvalid || s_cvalid || m_rready))
    else begin
        $error("handshake outputs active while reset is held");
        fail_reset++;
    end

    // still quiet on the first edge after release
    a_reset_exit: assert property (@(posedge aclk)
        $rose(rst_n) |-> !(s_arready || m_arvalid || s_rvalid || s_cvalid || m_rready))
    else begin
        $error("handshake outputs active on the first edge after reset");
        fail_exit++;
    end

    // ------------------------------------------------------------
    // hold under stall
    // ------------------------------------------------------------

    a_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr) && $stable(m_arlen))
    else begin
        $error("memory AR command changed while stalled");
        fail_ar_hold++;
    end

    a_r_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rlast))
    else begin
        $error("narrow read word changed while stalled");
        fail_r_hold++;
    end

    a_c_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        s_cvalid && !s_cready |=> s_cvalid)
    else begin
        $error("completion acknowledge dropped while stalled");
        fail_c_hold++;
    end

    // accepted command shows up one edge later, beat aligned
    a_ar_latency: assert property (@(posedge aclk) disable iff (!rst_n)
        s_arvalid && s_arready |=> m_arvalid
            && (m_araddr == ($past(s_araddr) & ~addr_t'(15)))
            && (m_arlen == len_t'((int'($past(s_arlen)) + 4) / 4 - 1)))
    else begin
        $error("memory AR command missing or wrong one cycle after acceptance");
        fail_ar_lat++;
    end

endmodule

/* tb/tb_axi_rd_width_convert.sv */
module tb_axi_rd_width_convert
    import axi_rd_pkg::*;
    ();

    localparam int num_tests     = 4;
    localparam int cmds_per_test = 10;
    localparam int num_cmds      = num_tests * cmds_per_test;

    logic    aclk      = 1'b0;
    logic    rst_n     = 1'b0;
    logic    endian    = 1'b0;
    addr_t   s_araddr  = '0;
    len_t    s_arlen   = '0;
    logic    s_arvalid = 1'b0;
    logic    s_rready  = 1'b0;
    logic    s_cready  = 1'b0;
    logic    m_arready = 1'b0;
    m_beat_t m_rdata   = '0;
    logic    m_rlast   = 1'b0;
    logic    m_rvalid  = 1'b0;
    logic    s_arready;
    s_word_t s_rdata;
    logic    s_rlast;
    logic    s_rvalid;
    logic    s_cvalid;
    addr_t   m_araddr;
    len_t    m_arlen;
    logic    m_arvalid;
    logic    m_rready;

    logic        stall_mode = 1'b0;
    int unsigned lcg_state  = 89909;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          total_words = 0;
    int          bursts_issued = 0;
    int          words_seen = 0;
    int          rlast_seen = 0;
    int          cpl_seen = 0;
    int          ar_checks = 0;
    int          r_checks = 0;
    int          c_checks = 0;
    int          end_checks = 0;
    int          ar_errors = 0;
    int          r_errors = 0;
    int          c_errors = 0;
    int          end_errors = 0;

    addr_t   cmd_addr [num_cmds];
    len_t    cmd_len [num_cmds];
    addr_t   exp_araddr_q [$];
    len_t    exp_arlen_q [$];
    addr_t   mem_addr_q [$];
    len_t    mem_len_q [$];
    s_word_t exp_word_q [$];
    logic    exp_last_q [$];
    s_word_t exp_w;
    logic    exp_l;

    always #2 aclk = ~aclk;

    axi_rd_width_convert UUT (
        .aclk(aclk), .rst_n(rst_n), .endian(endian),
        .s_araddr(s_araddr), .s_arlen(s_arlen), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rlast(s_rlast), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .s_cvalid(s_cvalid), .s_cready(s_cready),
        .m_araddr(m_araddr), .m_arlen(m_arlen), .m_arvalid(m_arvalid), .m_arready(m_arready),
        .m_rdata(m_rdata), .m_rlast(m_rlast), .m_rvalid(m_rvalid), .m_rready(m_rready)
    );

    bind axi_rd_width_convert axi_rd_assertions u_axi_rd_assertions (
        .aclk(aclk), .rst_n(rst_n),
        .s_araddr(s_araddr), .s_arlen(s_arlen), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .m_araddr(m_araddr), .m_arlen(m_arlen), .m_arvalid(m_arvalid), .m_arready(m_arready),
        .s_rdata(s_rdata), .s_rlast(s_rlast), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .s_cvalid(s_cvalid), .s_cready(s_cready), .m_rready(m_rready)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;      // low bits of an lcg cycle too fast
    endfunction

    function automatic s_word_t mem_word(input addr_t a);
        return a ^ 32'h5A5A0000;
    endfunction

    function automatic int total_errors();
        return ar_errors + r_errors + c_errors + end_errors
             + UUT.u_axi_rd_assertions.fail_count;
    endfunction

    task automatic issue_cmd(input addr_t addr, input len_t len);
        int    i;
        addr_t base;
        addr_t wa;
        base = addr & ~addr_t'(15);
        s_araddr  = addr;
        s_arlen   = len;
        s_arvalid = 1'b1;
        @(posedge aclk);
        while (!s_arready) @(posedge aclk);
        exp_araddr_q.push_back(base);
        exp_arlen_q.push_back(len_t'((int'(len) + 4) / 4 - 1));
        for (i = 0; i <= int'(len); i++) begin
            if (endian)
                wa = base + 16 * (i / 4) + 4 * (3 - i % 4);   // reversed inside a beat
            else
                wa = base + 4 * i;
            exp_word_q.push_back(mem_word(wa));
            exp_last_q.push_back(i == int'(len));
        end
        bursts_issued++;
        @(negedge aclk);
        s_arvalid = 1'b0;
    endtask

    // ------------------------------------------------------------
    // ready stalls and watchdog
    // ------------------------------------------------------------

    always @(negedge aclk) begin
        if (stall_mode) begin
            m_arready = (next_rand() % 4) != 0;
            s_rready  = (next_rand() % 3) != 0;
            s_cready  = (next_rand() % 2) != 0;
        end else begin
            m_arready = 1'b1;
            s_rready  = 1'b1;
            s_cready  = 1'b1;
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles, %0d of %0d words seen",
                     cycles, words_seen, total_words);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------

    always @(posedge aclk) begin
        if (rst_n && m_arvalid && m_arready) begin
            mem_addr_q.push_back(m_araddr);
            mem_len_q.push_back(m_arlen);
            if (exp_araddr_q.size() == 0) begin
                $display("** Error at %0t: memory AR command with no slave command", $time);
                ar_errors++;
            end else begin
                ar_checks++;
                assert (m_araddr == exp_araddr_q[0]) else begin
                    $display("** Error at %0t: m_araddr expected %08h, got %08h",
                             $time, exp_araddr_q[0], m_araddr);
                    ar_errors++;
                end
                assert (m_arlen == exp_arlen_q[0]) else begin
                    $display("** Error at %0t: m_arlen expected %0d, got %0d",
                             $time, exp_arlen_q[0], m_arlen);
                    ar_errors++;
                end
                void'(exp_araddr_q.pop_front());
                void'(exp_arlen_q.pop_front());
            end
        end
    end

    initial begin : mem_data
        addr_t a;
        len_t  n;
        int    b;
        int    w;
        forever begin
            @(negedge aclk);
            if (mem_addr_q.size() != 0) begin
                a = mem_addr_q.pop_front();
                n = mem_len_q.pop_front();
                repeat (next_rand() % 4) @(negedge aclk);
                for (b = 0; b <= int'(n); b++) begin
                    for (w = 0; w < word_ratio; w++)
                        m_rdata[w*32 +: 32] = mem_word(a + 16 * b + 4 * w);  // low address low bits
                    m_rlast  = (b == int'(n));
                    m_rvalid = 1'b1;
                    @(posedge aclk);
                    while (!m_rready) @(posedge aclk);
                    @(negedge aclk);
                    m_rvalid = 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // scoreboard
    // ------------------------------------------------------------

    always @(posedge aclk) begin
        if (rst_n && s_rvalid && s_rready) begin
            words_seen++;
            if (exp_word_q.size() == 0) begin
                $display("** Error at %0t: narrow word %08h arrived with no burst outstanding",
                         $time, s_rdata);
                r_errors++;
            end else begin
                exp_w = exp_word_q.pop_front();
                exp_l = exp_last_q.pop_front();
                r_checks++;
                assert (s_rdata == exp_w) else begin
                    $display("** Error at %0t: s_rdata expected %08h, got %08h",
                             $time, exp_w, s_rdata);
                    r_errors++;
                end
                assert (s_rlast == exp_l) else begin
                    $display("** Error at %0t: s_rlast expected %0b, got %0b",
                             $time, exp_l, s_rlast);
                    r_errors++;
                end
            end
        end
    end

    // s_cvalid follows the count of burst ends not yet acknowledged
    always @(posedge aclk) begin
        if (rst_n) begin
            c_checks++;
            assert (s_cvalid == (rlast_seen != cpl_seen)) else begin
                $display("** Error at %0t: s_cvalid expected %0b, got %0b",
                         $time, rlast_seen != cpl_seen, s_cvalid);
                c_errors++;
            end
            if (m_rvalid && m_rready && m_rlast)
                rlast_seen++;
            if (s_cvalid && s_cready)
                cpl_seen++;
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin : main
        int t;
        int c;
        int k;
        int err_before;
        int words_before;
        for (k = 0; k < num_cmds; k++) begin
            cmd_len[k]  = len_t'(next_rand() % 16);
            cmd_addr[k] = addr_t'(next_rand() & 32'h000F_FFFC);   // word aligned only
            total_words += int'(cmd_len[k]) + 1;
        end
        cycle_limit = 40 * total_words + 200;

        repeat (10) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        for (t = 0; t < num_tests; t++) begin
            err_before   = total_errors();
            words_before = words_seen;
            endian       = t[0];
            stall_mode   = (t >= 2);
            for (c = 0; c < cmds_per_test; c++) begin
                if (stall_mode)
                    repeat (next_rand() % 3) @(negedge aclk);
                issue_cmd(cmd_addr[t * cmds_per_test + c], cmd_len[t * cmds_per_test + c]);
            end
            while (exp_word_q.size() != 0 || cpl_seen != bursts_issued) @(posedge aclk);
            @(negedge aclk);
            $display("test %0d finished: endian %0d, stalls %0d, %0d words, %0d errors",
                     t, endian, stall_mode, words_seen - words_before,
                     total_errors() - err_before);
        end

        repeat (4) @(posedge aclk);
        end_checks++;
        assert (rlast_seen == bursts_issued && cpl_seen == bursts_issued) else begin
            $display("completion count mismatch: %0d bursts, %0d burst ends, %0d acks",
                     bursts_issued, rlast_seen, cpl_seen);
            end_errors++;
        end
        end_checks++;
        assert (words_seen == total_words) else begin
            $display("** Error at %0t: words_seen expected %0d, got %0d",
                     $time, total_words, words_seen);
            end_errors++;
        end

        $display("tests %0d, bursts %0d, words %0d, checks %0d, errors %0d",
                 num_tests, bursts_issued, words_seen,
                 ar_checks + r_checks + c_checks + end_checks, total_errors());
        if (total_errors() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* axi_rd_width_convert.f */
+incdir+hdl
hdl/axi_rd_pkg.sv
hdl/rd_beat_if.sv
hdl/ar_len_convert.sv
hdl/rdata_buffer.sv
hdl/beat_unpack.sv
hdl/axi_rd_width_convert.sv
tb/axi_rd_assertions.sv
tb/tb_axi_rd_width_convert.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_axi_rd_width_convert \
    -f axi_rd_width_convert.f -Mdir obj_dir

./obj_dir/Vtb_axi_rd_width_convert +verilator+error+limit+1000 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
